/* sram_pkg.sv */
/*
 * Memory-port definitions shared by the SRAM, the arbiter and both agents.
 * Modules pull these in with a wildcard import in their header.
 */
package sram_pkg;

  // Width of one write-enable lane; the byte count of a word is derived from it
  localparam int LANE_BITS = 8;

  // Kind of access an agent asks the SRAM for
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

endpackage

/* agent_pkg.sv */
/*
 * Agent identities and copy command status for the arbiter, the top level,
 * the copy engine and the checker.
 */
package agent_pkg;

  // Which agent owns the SRAM port in a given cycle
  typedef enum logic {
    AGENT_HOST = 1'b0,
    AGENT_COPY = 1'b1
  } agent_id_e;

  // Outcome of a copy command, reported with copy_done
  typedef enum logic {
    COPY_OK        = 1'b0,
    COPY_RANGE_ERR = 1'b1
  } copy_status_e;

endpackage

/* sync_sram_1rw.sv */
`timescale 1ns/1ps
/*
 * Single-port synchronous SRAM with one read or one write per cycle.
 * Writes honor per-byte enables and read data appears after the next edge.
 */
module sync_sram_1rw
  import sram_pkg::*;
#(
  parameter int DATA_BITS   = 32,
  parameter int NUM_ENTRIES = 48
) (
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic                                                   read_en,
  input  logic [$clog2(NUM_ENTRIES)-1:0]                         read_addr,
  output logic [DATA_BITS-1:0]                                   read_data,
  input  logic                                                   write_en,
  input  logic [(DATA_BITS+LANE_BITS-1)/LANE_BITS-1:0]           write_byte_en,
  input  logic [$clog2(NUM_ENTRIES)-1:0]                         write_addr,
  input  logic [DATA_BITS-1:0]                                   write_data
);

  localparam int BYTES = (DATA_BITS + LANE_BITS - 1) / LANE_BITS;

  logic [DATA_BITS-1:0] mem [NUM_ENTRIES];
  logic [DATA_BITS-1:0] read_data_q;
  logic [DATA_BITS-1:0] lane_mask;

  // --------------------------------------------------
  // Byte lanes
  // --------------------------------------------------

  // Each enable bit widens into a mask over its lane
  // The top lane is cut short when the width is not a whole number of bytes
  for (genvar i = 0; i < BYTES; i++) begin : g_lane
    localparam int LO = i * LANE_BITS;
    localparam int HI = ((i + 1) * LANE_BITS > DATA_BITS) ? DATA_BITS - 1
                                                          : (i + 1) * LANE_BITS - 1;
    assign lane_mask[HI:LO] = {(HI - LO + 1){write_byte_en[i]}};
  end

  // Disabled lanes keep their old contents
  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= (mem[write_addr] & ~lane_mask) | (write_data & lane_mask);
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------

  // The address is sampled at the edge and the word is visible in the next cycle
  // Without read_en the register holds the last word read
  always_ff @(posedge clk) begin
    if (read_en) begin
      read_data_q <= mem[read_addr];
    end
  end

  assign read_data = read_data_q;

  // --------------------------------------------------
  // Usage checks
  // --------------------------------------------------

  // A single port serves one access per cycle
  a_one_access: assert property (@(posedge clk) disable iff (!reset)
    !(read_en && write_en))
    else $error("SRAM read and write enabled in the same cycle");

  // Address bits can name more words than exist, since the count is not a power of two
  a_write_range: assert property (@(posedge clk) disable iff (!reset)
    write_en |-> (write_addr < NUM_ENTRIES))
    else $error("SRAM write address %0h past the last entry", write_addr);

  a_read_range: assert property (@(posedge clk) disable iff (!reset)
    read_en |-> (read_addr < NUM_ENTRIES))
    else $error("SRAM read address %0h past the last entry", read_addr);

endmodule

/* sram_arbiter.sv */
`timescale 1ns/1ps
/*
 * Fixed-priority arbiter between the host port and the copy engine.
 * It drives the single SRAM port and steers read data back to the owner.
 */
module sram_arbiter
  import sram_pkg::*, agent_pkg::*;
#(
  parameter int DATA_BITS   = 32,
  parameter int NUM_ENTRIES = 48
) (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic                                         host_mem_req,
  input  mem_op_e                                      host_mem_op,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               host_mem_addr,
  input  logic [(DATA_BITS+LANE_BITS-1)/LANE_BITS-1:0] host_mem_byte_en,
  input  logic [DATA_BITS-1:0]                         host_mem_wdata,
  input  logic                                         copy_mem_req,
  input  mem_op_e                                      copy_mem_op,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               copy_mem_addr,
  input  logic [(DATA_BITS+LANE_BITS-1)/LANE_BITS-1:0] copy_mem_byte_en,
  input  logic [DATA_BITS-1:0]                         copy_mem_wdata,
  output logic                                         copy_mem_grant,
  output logic                                         host_rdata_valid,
  output logic                                         copy_rdata_valid,
  output logic [DATA_BITS-1:0]                         mem_rdata,
  output agent_id_e                                    grant_owner,
  output logic                                         read_en,
  output logic [$clog2(NUM_ENTRIES)-1:0]               read_addr,
  output logic                                         write_en,
  output logic [(DATA_BITS+LANE_BITS-1)/LANE_BITS-1:0] write_byte_en,
  output logic [$clog2(NUM_ENTRIES)-1:0]               write_addr,
  output logic [DATA_BITS-1:0]                         write_data,
  input  logic [DATA_BITS-1:0]                         read_data
);

  logic      active;
  mem_op_e   sel_op;
  logic      rd_valid_q;
  agent_id_e rd_owner_q;

  // The host always wins, so the copy engine only ever gets idle host cycles
  assign grant_owner    = host_mem_req ? AGENT_HOST : AGENT_COPY;
  assign copy_mem_grant = copy_mem_req && !host_mem_req;
  assign active         = host_mem_req || copy_mem_req;

  // Port muxing follows the owner; read and write share one address
  assign sel_op        = (grant_owner == AGENT_HOST) ? host_mem_op : copy_mem_op;
  assign read_addr     = (grant_owner == AGENT_HOST) ? host_mem_addr : copy_mem_addr;
  assign write_addr    = read_addr;
  assign write_byte_en = (grant_owner == AGENT_HOST) ? host_mem_byte_en : copy_mem_byte_en;
  assign write_data    = (grant_owner == AGENT_HOST) ? host_mem_wdata : copy_mem_wdata;
  assign read_en       = active && (sel_op == MEM_READ);
  assign write_en      = active && (sel_op == MEM_WRITE);

  // Remember for one cycle who owned the read, since the data lands a cycle later
  always_ff @(posedge clk) begin
    if (!reset) begin
      rd_valid_q <= 1'b0;
      rd_owner_q <= AGENT_HOST;
    end else begin
      rd_valid_q <= read_en;
      rd_owner_q <= grant_owner;
    end
  end

  assign host_rdata_valid = rd_valid_q && (rd_owner_q == AGENT_HOST);
  assign copy_rdata_valid = rd_valid_q && (rd_owner_q == AGENT_COPY);
  assign mem_rdata        = read_data;

  // The host port has no back-pressure, so a copy grant must never collide with it
  a_host_priority: assert property (@(posedge clk) disable iff (!reset)
    host_mem_req |-> !copy_mem_grant)
    else $error("Copy engine granted while the host was requesting");

endmodule

/* host_port.sv */
`timescale 1ns/1ps
/*
 * Host access agent. Single-cycle strobes become SRAM requests and reads
 * respond one cycle later; out-of-range addresses answer with an error.
 */
module host_port
  import sram_pkg::*;
#(
  parameter int DATA_BITS   = 32,
  parameter int NUM_ENTRIES = 48
) (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic                                         host_req,
  input  mem_op_e                                      host_op,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               host_addr,
  input  logic [(DATA_BITS+LANE_BITS-1)/LANE_BITS-1:0] host_byte_en,
  input  logic [DATA_BITS-1:0]                         host_wdata,
  output logic                                         host_rsp_valid,
  output logic                                         host_rsp_error,
  output logic [DATA_BITS-1:0]                         host_rdata,
  output logic                                         host_mem_req,
  output mem_op_e                                      host_mem_op,
  output logic [$clog2(NUM_ENTRIES)-1:0]               host_mem_addr,
  output logic [(DATA_BITS+LANE_BITS-1)/LANE_BITS-1:0] host_mem_byte_en,
  output logic [DATA_BITS-1:0]                         host_mem_wdata,
  input  logic                                         host_rdata_valid,
  input  logic [DATA_BITS-1:0]                         mem_rdata
);

  localparam int ADDR_BITS = $clog2(NUM_ENTRIES);

  logic in_range;
  logic error_q;

  // One extra bit keeps the compare exact when the entry count is a power of two
  assign in_range = {1'b0, host_addr} < (ADDR_BITS + 1)'(NUM_ENTRIES);

  // Only in-range strobes reach the SRAM
  // The host always wins arbitration, so the request lasts exactly the strobe cycle
  assign host_mem_req     = host_req && in_range;
  assign host_mem_op      = host_op;
  assign host_mem_addr    = host_addr;
  assign host_mem_byte_en = host_byte_en;
  assign host_mem_wdata   = host_wdata;

  // The error strobe lines up with where read data would have appeared
  always_ff @(posedge clk) begin
    if (!reset) begin
      error_q <= 1'b0;
    end else begin
      error_q <= host_req && !in_range;
    end
  end

  assign host_rsp_error = error_q;

  // The arbiter flags only reads that the host owned, so writes stay silent
  assign host_rsp_valid = host_rdata_valid;
  assign host_rdata     = mem_rdata;

endmodule

/* copy_engine.sv */
`timescale 1ns/1ps
/*
 * Block copy agent. Each word is read from the source range and written to
 * the destination, using only the cycles the host leaves free.
 */
module copy_engine
  import sram_pkg::*, agent_pkg::*;
#(
  parameter int DATA_BITS   = 32,
  parameter int NUM_ENTRIES = 48
) (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic                                         copy_start,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               copy_src,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               copy_dst,
  input  logic [$clog2(NUM_ENTRIES+1)-1:0]             copy_count,
  output logic                                         copy_busy,
  output logic                                         copy_done,
  output logic                                         copy_error,
  output logic                                         copy_mem_req,
  output mem_op_e                                      copy_mem_op,
  output logic [$clog2(NUM_ENTRIES)-1:0]               copy_mem_addr,
  output logic [(DATA_BITS+LANE_BITS-1)/LANE_BITS-1:0] copy_mem_byte_en,
  output logic [DATA_BITS-1:0]                         copy_mem_wdata,
  input  logic                                         copy_mem_grant,
  input  logic                                         copy_rdata_valid,
  input  logic [DATA_BITS-1:0]                         mem_rdata
);

  localparam int ADDR_BITS = $clog2(NUM_ENTRIES);
  localparam int CNT_BITS  = $clog2(NUM_ENTRIES + 1);
  localparam int SUM_BITS  = ADDR_BITS + 2;

  localparam logic [2:0] ST_IDLE      = 3'd0;
  localparam logic [2:0] ST_READ      = 3'd1;
  localparam logic [2:0] ST_WAIT_DATA = 3'd2;
  localparam logic [2:0] ST_WRITE     = 3'd3;
  localparam logic [2:0] ST_FINISH    = 3'd4;

  logic [2:0]           state_q;
  copy_status_e         status_q;
  logic [ADDR_BITS-1:0] src_q;
  logic [ADDR_BITS-1:0] dst_q;
  logic [CNT_BITS-1:0]  remaining_q;
  logic [DATA_BITS-1:0] hold_q;
  logic [SUM_BITS-1:0]  src_end;
  logic [SUM_BITS-1:0]  dst_end;
  logic                 range_bad;
  logic                 start_ok;
  logic                 word_done;

  // --------------------------------------------------
  // Command check
  // --------------------------------------------------

  // A range may end exactly at the last entry but not beyond it
  assign src_end   = SUM_BITS'(copy_src) + SUM_BITS'(copy_count);
  assign dst_end   = SUM_BITS'(copy_dst) + SUM_BITS'(copy_count);
  assign range_bad = (src_end > SUM_BITS'(NUM_ENTRIES)) || (dst_end > SUM_BITS'(NUM_ENTRIES));

  // Commands that arrive while busy are dropped
  assign start_ok = copy_start && (state_q == ST_IDLE);

  // A word is finished once its write wins the port
  assign word_done = copy_mem_grant && ((state_q == ST_WAIT_DATA) || (state_q == ST_WRITE));

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------

  // Rejected and empty commands go straight to finish
  // A request that loses to the host stays in its state and is retried
  always_ff @(posedge clk) begin
    if (!reset) begin
      state_q  <= ST_IDLE;
      status_q <= COPY_OK;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_ok) begin
            status_q <= range_bad ? COPY_RANGE_ERR : COPY_OK;
            state_q  <= (range_bad || copy_count == '0) ? ST_FINISH : ST_READ;
          end
        end
        ST_READ: begin
          if (copy_mem_grant) begin
            state_q <= ST_WAIT_DATA;
          end
        end
        ST_WAIT_DATA, ST_WRITE: begin
          if (word_done) begin
            state_q <= (remaining_q == CNT_BITS'(1)) ? ST_FINISH : ST_READ;
          end else begin
            state_q <= ST_WRITE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Addresses and the word count advance together after each write
  always_ff @(posedge clk) begin
    if (start_ok) begin
      src_q       <= copy_src;
      dst_q       <= copy_dst;
      remaining_q <= copy_count;
    end else if (word_done) begin
      src_q       <= src_q + 1'b1;
      dst_q       <= dst_q + 1'b1;
      remaining_q <= remaining_q - 1'b1;
    end
  end

  // Keeps the source word for a write that lost arbitration
  always_ff @(posedge clk) begin
    if (copy_rdata_valid) begin
      hold_q <= mem_rdata;
    end
  end

  // --------------------------------------------------
  // Memory request and status
  // --------------------------------------------------

  // Fresh read data goes straight out, which gives two cycles per word when the host is idle
  assign copy_mem_req     = (state_q == ST_READ) || (state_q == ST_WAIT_DATA) ||
                            (state_q == ST_WRITE);
  assign copy_mem_op      = (state_q == ST_READ) ? MEM_READ : MEM_WRITE;
  assign copy_mem_addr    = (state_q == ST_READ) ? src_q : dst_q;
  assign copy_mem_byte_en = '1;
  assign copy_mem_wdata   = copy_rdata_valid ? mem_rdata : hold_q;

  assign copy_busy  = (state_q != ST_IDLE);
  assign copy_done  = (state_q == ST_FINISH);
  assign copy_error = copy_done && (status_q == COPY_RANGE_ERR);

  // Done is a single strobe, and a new command is accepted from the next cycle on
  a_done_ends_busy: assert property (@(posedge clk) disable iff (!reset)
    copy_done |=> !copy_busy)
    else $error("Copy engine still busy after copy_done");

endmodule

/* scratchpad_top.sv */
`timescale 1ns/1ps
/*
 * Scratchpad top level. It sets the word width and entry count and wires the
 * host port and copy engine through the arbiter to the SRAM.
 */
module scratchpad_top
  import sram_pkg::*, agent_pkg::*;
#(
  parameter int DATA_BITS   = 32,
  parameter int NUM_ENTRIES = 48
) (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic                                         host_req,
  input  mem_op_e                                      host_op,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               host_addr,
  input  logic [(DATA_BITS+LANE_BITS-1)/LANE_BITS-1:0] host_byte_en,
  input  logic [DATA_BITS-1:0]                         host_wdata,
  output logic                                         host_rsp_valid,
  output logic                                         host_rsp_error,
  output logic [DATA_BITS-1:0]                         host_rdata,
  input  logic                                         copy_start,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               copy_src,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               copy_dst,
  input  logic [$clog2(NUM_ENTRIES+1)-1:0]             copy_count,
  output logic                                         copy_busy,
  output logic                                         copy_done,
  output logic                                         copy_error,
  output agent_id_e                                    grant_owner
);

  localparam int ADDR_BITS = $clog2(NUM_ENTRIES);
  localparam int BYTES     = (DATA_BITS + LANE_BITS - 1) / LANE_BITS;

  // Host request group
  logic                 host_mem_req;
  mem_op_e              host_mem_op;
  logic [ADDR_BITS-1:0] host_mem_addr;
  logic [BYTES-1:0]     host_mem_byte_en;
  logic [DATA_BITS-1:0] host_mem_wdata;
  logic                 host_rdata_valid;

  // Copy request group
  logic                 copy_mem_req;
  mem_op_e              copy_mem_op;
  logic [ADDR_BITS-1:0] copy_mem_addr;
  logic [BYTES-1:0]     copy_mem_byte_en;
  logic [DATA_BITS-1:0] copy_mem_wdata;
  logic                 copy_mem_grant;
  logic                 copy_rdata_valid;

  // Shared return data and the SRAM port
  logic [DATA_BITS-1:0] mem_rdata;
  logic                 read_en;
  logic [ADDR_BITS-1:0] read_addr;
  logic [DATA_BITS-1:0] read_data;
  logic                 write_en;
  logic [BYTES-1:0]     write_byte_en;
  logic [ADDR_BITS-1:0] write_addr;
  logic [DATA_BITS-1:0] write_data;

  host_port #(.DATA_BITS(DATA_BITS), .NUM_ENTRIES(NUM_ENTRIES)) u_host_port (
    .clk, .reset,
    .host_req, .host_op, .host_addr, .host_byte_en, .host_wdata,
    .host_rsp_valid, .host_rsp_error, .host_rdata,
    .host_mem_req, .host_mem_op, .host_mem_addr, .host_mem_byte_en, .host_mem_wdata,
    .host_rdata_valid, .mem_rdata
  );

  copy_engine #(.DATA_BITS(DATA_BITS), .NUM_ENTRIES(NUM_ENTRIES)) u_copy_engine (
    .clk, .reset,
    .copy_start, .copy_src, .copy_dst, .copy_count,
    .copy_busy, .copy_done, .copy_error,
    .copy_mem_req, .copy_mem_op, .copy_mem_addr, .copy_mem_byte_en, .copy_mem_wdata,
    .copy_mem_grant, .copy_rdata_valid, .mem_rdata
  );

  sram_arbiter #(.DATA_BITS(DATA_BITS), .NUM_ENTRIES(NUM_ENTRIES)) u_arbiter (
    .clk, .reset,
    .host_mem_req, .host_mem_op, .host_mem_addr, .host_mem_byte_en, .host_mem_wdata,
    .copy_mem_req, .copy_mem_op, .copy_mem_addr, .copy_mem_byte_en, .copy_mem_wdata,
    .copy_mem_grant, .host_rdata_valid, .copy_rdata_valid, .mem_rdata, .grant_owner,
    .read_en, .read_addr, .write_en, .write_byte_en, .write_addr, .write_data,
    .read_data
  );

  sync_sram_1rw #(.DATA_BITS(DATA_BITS), .NUM_ENTRIES(NUM_ENTRIES)) u_sram (
    .clk, .reset,
    .read_en, .read_addr, .read_data,
    .write_en, .write_byte_en, .write_addr, .write_data
  );

endmodule

/* scratchpad_checker.sv */
`timescale 1ns/1ps
/*
 * Testbench checker. Keeps a shadow of the SRAM from the host and copy
 * commands seen on the top-level ports and compares every response.
 */
module scratchpad_checker
  import sram_pkg::*, agent_pkg::*;
#(
  parameter int DATA_BITS   = 32,
  parameter int NUM_ENTRIES = 48
) (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic                                         host_req,
  input  mem_op_e                                      host_op,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               host_addr,
  input  logic [(DATA_BITS+LANE_BITS-1)/LANE_BITS-1:0] host_byte_en,
  input  logic [DATA_BITS-1:0]                         host_wdata,
  input  logic                                         host_rsp_valid,
  input  logic                                         host_rsp_error,
  input  logic [DATA_BITS-1:0]                         host_rdata,
  input  logic                                         copy_start,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               copy_src,
  input  logic [$clog2(NUM_ENTRIES)-1:0]               copy_dst,
  input  logic [$clog2(NUM_ENTRIES+1)-1:0]             copy_count,
  input  logic                                         copy_busy,
  input  logic                                         copy_done,
  input  logic                                         copy_error,
  input  agent_id_e                                    grant_owner,
  output int                                           error_count,
  output logic                                         copy_open
);

  localparam int BYTES = (DATA_BITS + LANE_BITS - 1) / LANE_BITS;

  // Words never written stay X here just as they do in the SRAM
  logic [DATA_BITS-1:0] shadow [NUM_ENTRIES];
  logic [DATA_BITS-1:0] rd_word;
  logic [DATA_BITS-1:0] mask;
  logic                 rd_expect;
  logic                 err_expect;
  logic                 busy_expect;
  logic                 cp_bad;
  logic                 cp_host_seen;
  int                   cp_src;
  int                   cp_dst;
  int                   cp_count;
  int                   cp_age;

  initial begin
    error_count  = 0;
    copy_open    = 1'b0;
    rd_expect    = 1'b0;
    err_expect   = 1'b0;
    busy_expect  = 1'b0;
    cp_host_seen = 1'b0;
  end

  task automatic report_mismatch(string name, logic [DATA_BITS-1:0] expected,
                                 logic [DATA_BITS-1:0] actual);
    $display("Error: %s expected %h got %h at %0t", name, expected, actual, $time);
    error_count++;
  endtask

  task automatic report_problem(string text);
    $display("%s at %0t", text, $time);
    error_count++;
  endtask

  // Bit b belongs to byte lane b / 8
  function automatic logic [DATA_BITS-1:0] lanes_to_mask(logic [BYTES-1:0] be);
    logic [DATA_BITS-1:0] m;
    for (int b = 0; b < DATA_BITS; b++) begin
      m[b] = be[b / LANE_BITS];
    end
    return m;
  endfunction

  // --------------------------------------------------
  // Per-edge model
  // --------------------------------------------------

  // Everything is sampled at the rising edge, before the DUT registers move
  always @(posedge clk) begin
    if (!reset) begin
      rd_expect  = 1'b0;
      err_expect = 1'b0;
      copy_open  = 1'b0;
    end else begin
      // The engine is busy from the cycle after an accepted command through its done cycle
      busy_expect = copy_open;
      if (copy_busy !== busy_expect) begin
        report_mismatch("copy_busy", busy_expect, copy_busy);
      end

      // Responses owed by the strobe of the previous cycle
      if (host_rsp_valid !== rd_expect) begin
        report_mismatch("host_rsp_valid", rd_expect, host_rsp_valid);
      end else if (rd_expect && host_rdata !== rd_word) begin
        report_mismatch("host_rdata", rd_word, host_rdata);
      end
      if (host_rsp_error !== err_expect) begin
        report_mismatch("host_rsp_error", err_expect, host_rsp_error);
      end
      rd_expect  = 1'b0;
      err_expect = 1'b0;

      // A host strobe wins the port at once or is refused for its address
      if (host_req) begin
        if (host_addr >= NUM_ENTRIES) begin
          err_expect = 1'b1;
        end else begin
          if (copy_open) begin
            cp_host_seen = 1'b1;
          end
          if (grant_owner !== AGENT_HOST) begin
            report_mismatch("grant_owner", AGENT_HOST, grant_owner);
          end
          if (host_op == MEM_READ) begin
            rd_expect = 1'b1;
            rd_word   = shadow[host_addr];
          end else begin
            mask              = lanes_to_mask(host_byte_en);
            shadow[host_addr] = (shadow[host_addr] & ~mask) | (host_wdata & mask);
          end
        end
      end

      // The copy lands in the shadow in one step once it reports done
      if (copy_open) begin
        cp_age++;
      end
      if (copy_done) begin
        if (!copy_open) begin
          report_problem("copy_done seen with no copy command in progress");
        end else begin
          if (copy_error !== cp_bad) begin
            report_mismatch("copy_error", cp_bad, copy_error);
          end
          if (cp_bad && cp_age != 1) begin
            report_problem($sformatf("Rejected copy ended %0d cycles after its command",
                                     cp_age));
          end
          // Without host traffic each word takes a read and a write, then one done cycle
          if (!cp_bad && !cp_host_seen && cp_age != 2 * cp_count + 1) begin
            report_problem($sformatf("Copy of %0d words on an idle port took %0d cycles",
                                     cp_count, cp_age));
          end
          if (!cp_bad) begin
            // Forward order, word by word, like the engine itself
            for (int i = 0; i < cp_count; i++) begin
              shadow[cp_dst + i] = shadow[cp_src + i];
            end
          end
          copy_open = 1'b0;
        end
      end else if (copy_error) begin
        report_problem("copy_error raised without copy_done");
      end

      // Commands seen while busy are dropped by the engine
      if (copy_start && !busy_expect) begin
        copy_open    = 1'b1;
        cp_src       = copy_src;
        cp_dst       = copy_dst;
        cp_count     = copy_count;
        cp_age       = 0;
        cp_host_seen = 1'b0;
        cp_bad       = (cp_src + cp_count > NUM_ENTRIES) ||
                       (cp_dst + cp_count > NUM_ENTRIES);
      end
    end
  end

endmodule

/* tb_scratchpad.sv */
`timescale 1ns/1ps
/*
 * Testbench for the scratchpad. A table of host and copy commands is applied
 * in a loop, while scratchpad_checker compares every response.
 */
module tb_scratchpad;
  import sram_pkg::*, agent_pkg::*;

  localparam int DATA_BITS   = 32;
  localparam int NUM_ENTRIES = 48;
  localparam int ADDR_BITS   = $clog2(NUM_ENTRIES);
  localparam int CNT_BITS    = $clog2(NUM_ENTRIES + 1);
  localparam int BYTES       = (DATA_BITS + LANE_BITS - 1) / LANE_BITS;

  // Row kinds of the stimulus table
  localparam int K_HOST = 0;
  localparam int K_COPY = 1;
  localparam int K_IDLE = 2;
  localparam int K_WAIT = 3;

  logic                 clk;
  logic                 reset;
  logic                 host_req;
  mem_op_e              host_op;
  logic [ADDR_BITS-1:0] host_addr;
  logic [BYTES-1:0]     host_byte_en;
  logic [DATA_BITS-1:0] host_wdata;
  logic                 host_rsp_valid;
  logic                 host_rsp_error;
  logic [DATA_BITS-1:0] host_rdata;
  logic                 copy_start;
  logic [ADDR_BITS-1:0] copy_src;
  logic [ADDR_BITS-1:0] copy_dst;
  logic [CNT_BITS-1:0]  copy_count;
  logic                 copy_busy;
  logic                 copy_done;
  logic                 copy_error;
  agent_id_e            grant_owner;

  int  checker_errors;
  logic copy_open;
  int  tb_errors;
  int  seed;
  int  max_count;
  bit  table_ready = 1'b0;

  // One entry per row: kind, host op, address or copy source, copy destination,
  // copy count or idle cycles, and whether a write uses all byte lanes
  int      row_kind[$];
  mem_op_e row_op[$];
  int      row_a[$];
  int      row_d[$];
  int      row_n[$];
  bit      row_full[$];

  scratchpad_top #(.DATA_BITS(DATA_BITS), .NUM_ENTRIES(NUM_ENTRIES)) UUT (.*);

  scratchpad_checker #(.DATA_BITS(DATA_BITS), .NUM_ENTRIES(NUM_ENTRIES)) u_checker (
    .*,
    .error_count(checker_errors)
  );

  always #4 clk = ~clk;

  task automatic add_row(int kind, mem_op_e op, int a, int d, int n, bit full);
    row_kind.push_back(kind);
    row_op.push_back(op);
    row_a.push_back(a);
    row_d.push_back(d);
    row_n.push_back(n);
    row_full.push_back(full);
  endtask

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------

  task automatic build_table();
    // Known full words first, then a partial write merged into one of them
    add_row(K_HOST, MEM_WRITE, 2, 0, 0, 1'b1);
    add_row(K_HOST, MEM_WRITE, 3, 0, 0, 1'b1);
    add_row(K_HOST, MEM_READ, 2, 0, 0, 1'b0);
    add_row(K_HOST, MEM_WRITE, 2, 0, 0, 1'b0);
    add_row(K_HOST, MEM_READ, 2, 0, 0, 1'b0);
    // Addresses past the last entry answer with an error and touch nothing
    add_row(K_HOST, MEM_WRITE, 50, 0, 0, 1'b1);
    add_row(K_HOST, MEM_READ, 63, 0, 0, 1'b0);
    add_row(K_HOST, MEM_READ, 3, 0, 0, 1'b0);
    // Copy source words and the targets of the dropped and rejected copies
    for (int i = 10; i < 14; i++) begin
      add_row(K_HOST, MEM_WRITE, i, 0, 0, 1'b1);
    end
    add_row(K_HOST, MEM_WRITE, 30, 0, 0, 1'b1);
    add_row(K_HOST, MEM_WRITE, 45, 0, 0, 1'b1);
    add_row(K_IDLE, MEM_READ, 0, 0, 2, 1'b0);
    // Host traffic on other words while the copy runs, and a second command
    // that arrives while busy
    add_row(K_COPY, MEM_READ, 10, 20, 4, 1'b0);
    add_row(K_HOST, MEM_READ, 2, 0, 0, 1'b0);
    add_row(K_HOST, MEM_WRITE, 3, 0, 0, 1'b0);
    add_row(K_HOST, MEM_READ, 3, 0, 0, 1'b0);
    add_row(K_COPY, MEM_READ, 0, 30, 2, 1'b0);
    add_row(K_WAIT, MEM_READ, 0, 0, 0, 1'b0);
    add_row(K_HOST, MEM_READ, 20, 0, 0, 1'b0);
    add_row(K_HOST, MEM_READ, 23, 0, 0, 1'b0);
    add_row(K_HOST, MEM_READ, 30, 0, 0, 1'b0);
    // Destination range runs one word past the end
    add_row(K_COPY, MEM_READ, 40, 45, 4, 1'b0);
    add_row(K_WAIT, MEM_READ, 0, 0, 0, 1'b0);
    add_row(K_HOST, MEM_READ, 45, 0, 0, 1'b0);
    // Copy on an otherwise idle port
    add_row(K_COPY, MEM_READ, 2, 12, 2, 1'b0);
    add_row(K_WAIT, MEM_READ, 0, 0, 0, 1'b0);
    add_row(K_HOST, MEM_READ, 12, 0, 0, 1'b0);
    add_row(K_HOST, MEM_READ, 13, 0, 0, 1'b0);
    add_row(K_IDLE, MEM_READ, 0, 0, 3, 1'b0);
  endtask

  // Busy is looked at on the falling edge, where it is settled
  task automatic wait_copy_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (copy_busy && waited < 4 * max_count + 20) begin
      @(negedge clk);
      waited++;
    end
    if (copy_busy) begin
      $display("Copy engine still busy %0d cycles after the wait began", waited);
      tb_errors++;
    end
  endtask

  // Every row drives one strobe cycle; idle and wait rows keep the strobes low
  task automatic apply_row(int r);
    @(posedge clk);
    host_req     <= (row_kind[r] == K_HOST);
    copy_start   <= (row_kind[r] == K_COPY);
    host_op      <= row_op[r];
    host_addr    <= ADDR_BITS'(row_a[r]);
    host_wdata   <= $random(seed);
    host_byte_en <= row_full[r] ? '1 : BYTES'($random(seed));
    copy_src     <= ADDR_BITS'(row_a[r]);
    copy_dst     <= ADDR_BITS'(row_d[r]);
    copy_count   <= CNT_BITS'(row_n[r]);
    if (row_kind[r] == K_IDLE) begin
      repeat (row_n[r] - 1) @(posedge clk);
    end
    if (row_kind[r] == K_WAIT) begin
      wait_copy_idle();
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    clk          = 1'b0;
    reset        = 1'b0;
    host_req     = 1'b0;
    host_op      = MEM_READ;
    host_addr    = '0;
    host_byte_en = '0;
    host_wdata   = '0;
    copy_start   = 1'b0;
    copy_src     = '0;
    copy_dst     = '0;
    copy_count   = '0;
    tb_errors    = 0;
    seed         = 38;
    build_table();
    max_count = 0;
    foreach (row_kind[r]) begin
      if (row_kind[r] == K_COPY && row_n[r] > max_count) begin
        max_count = row_n[r];
      end
    end
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b1;
    foreach (row_kind[r]) begin
      apply_row(r);
    end
    if (copy_open) begin
      $display("A copy command was still open when the table ended");
      tb_errors++;
    end
    $display("Checks done with %0d checker errors and %0d testbench errors",
             checker_errors, tb_errors);
    if (checker_errors == 0 && tb_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Each row is allowed a worst case copy plus some margin, and reset on top
  initial begin
    int limit;
    wait (table_ready);
    limit = row_kind.size() * (4 * max_count + 20);
    repeat (limit + 5) @(posedge clk);
    $display("Watchdog expired after %0d cycles with %0d errors so far",
             limit, checker_errors + tb_errors);
    $display("tests failed");
    $finish;
  end

endmodule

/* all.f */
sram_pkg.sv
agent_pkg.sv
sync_sram_1rw.sv
sram_arbiter.sv
host_port.sv
copy_engine.sv
scratchpad_top.sv
scratchpad_checker.sv
tb_scratchpad.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_scratchpad
FILELIST = all.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
